/* source/starship_pkg.sv */
// Starship game package: timing constants, counter widths and the game state encoding
package starship_pkg;

	// ----------------------------------------
	// Button debounce
	// ----------------------------------------
	localparam int DEBOUNCE_CYCLES = 8;                      // Short for simulation
	localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES);
	localparam logic [DEBOUNCE_W-1:0] DEBOUNCE_LAST = DEBOUNCE_W'(DEBOUNCE_CYCLES - 1);

	// ----------------------------------------
	// Game tick and monster timing
	// ----------------------------------------
	localparam int TICK_CYCLES = 16;                         // board_clk cycles per tick
	localparam int TICK_W      = $clog2(TICK_CYCLES);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICK_CYCLES - 1);

	localparam int SPAWN_BASE   = 4;                         // Min wait, in ticks
	localparam int MONSTER_LIFE = 24;                        // Ticks before a loss
	localparam int LANE_W       = $clog2(MONSTER_LIFE + 1);  // Covers wait and life
	localparam logic [LANE_W-1:0] LANE_SPAWN = LANE_W'(SPAWN_BASE);
	localparam logic [LANE_W-1:0] LANE_LIFE  = LANE_W'(MONSTER_LIFE);

	// Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
	localparam logic [7:0] LFSR_TAPS = 8'hB8;
	localparam logic [7:0] LFSR_SEED = 8'hA5;               // Must not be zero

	// ----------------------------------------
	// Display and score
	// ----------------------------------------
	localparam int SCAN_CYCLES = 4;                          // Cycles per lit digit
	localparam int SCAN_W      = $clog2(SCAN_CYCLES);
	localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_CYCLES - 1);

	localparam int SCORE_W = 8;
	localparam logic [SCORE_W-1:0] SCORE_MAX = '1;          // Saturation point

	// Game states, numbers also shown on digit 6
	typedef enum logic [1:0] {
		INIT = 2'd0,
		PLAY = 2'd1,
		OVER = 2'd2
	} game_state_t;

endpackage

/* source/button_debouncer.sv */
// Button debouncer: synchronizes a push button and emits one pulse per stable press
`timescale 1ns/1ps

module button_debouncer
(
	input  logic board_clk,
	input  logic Reset,
	input  logic btn,     // Raw board button
	output logic pulse    // One cycle per accepted press
);

	logic sync_q1;      // Metastability stage
	logic sync_q2;      // Clean sampled level
	logic armed;        // High while waiting for a press
	logic [starship_pkg::DEBOUNCE_W-1:0] count;

	// ----------------------------------------
	// Synchronizer
	// ----------------------------------------
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
		begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
		end
		else
		begin
			sync_q1 <= btn;
			sync_q2 <= sync_q1;
		end
	end

	// ----------------------------------------
	// Stability counter and arm flag
	// ----------------------------------------
	// Armed: count high samples. Disarmed: count low samples before re-arming
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
		begin
			count <= '0;
			armed <= 1'b1;
			pulse <= 1'b0;
		end
		else
		begin
			pulse <= 1'b0;                                       // Default quiet
			if (sync_q2 == armed)                                // Level we wait for
			begin
				if (count == starship_pkg::DEBOUNCE_LAST)
				begin
					count <= '0;
					armed <= ~armed;                             // Swap target level
					pulse <= armed;                              // Fire only on the press side
				end
				else
					count <= count + 1'b1;
			end
			else
				count <= '0;                                     // Bounce, start over
		end
	end

endmodule

/* source/lfsr_random.sv */
// Random source: 8-bit Galois LFSR stepped once per game tick
`timescale 1ns/1ps

module lfsr_random
(
	input  logic       board_clk,
	input  logic       Reset,
	input  logic       step,          // Game tick
	output logic [7:0] random_byte    // Nibbles feed the two lanes
);

	logic [7:0] lfsr;
	logic [7:0] lfsr_next;

	// Shift right, fold taps in when bit 0 falls out
	always_comb
	begin
		lfsr_next = {1'b0, lfsr[7:1]};
		if (lfsr[0])
			lfsr_next = lfsr_next ^ starship_pkg::LFSR_TAPS;
	end

	// Frozen between ticks, so values only change while playing
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
			lfsr <= starship_pkg::LFSR_SEED;        // Nonzero seed, never locks up
		else if (step)
			lfsr <= lfsr_next;
	end

	assign random_byte = lfsr;

endmodule

/* source/starship_game_fsm.sv */
// Game controller: INIT/PLAY/OVER sequencing, game tick divider and score counter
`timescale 1ns/1ps

module starship_game_fsm
(
	input  logic                               board_clk,
	input  logic                               Reset,
	input  logic                               start_pulse,     // Centre button
	input  logic                               cleared_top,
	input  logic                               cleared_bottom,
	input  logic                               expired_top,
	input  logic                               expired_bottom,
	output starship_pkg::game_state_t          game_state,
	output logic                               game_tick,       // One cycle per tick
	output logic [starship_pkg::SCORE_W-1:0]   score
);

	logic [starship_pkg::TICK_W-1:0]  tick_cnt;
	logic [1:0]                       clear_inc;   // 0, 1 or 2 clears this cycle
	logic [starship_pkg::SCORE_W:0]   score_sum;   // One extra bit for overflow

	assign clear_inc = {1'b0, cleared_top} + {1'b0, cleared_bottom};
	assign score_sum = {1'b0, score} + {{(starship_pkg::SCORE_W - 1){1'b0}}, clear_inc};

	// Tick only while playing
	assign game_tick = (game_state == starship_pkg::PLAY) &&
	                   (tick_cnt == starship_pkg::TICK_LAST);

	// ----------------------------------------
	// State, divider and score
	// ----------------------------------------
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
		begin
			game_state <= starship_pkg::INIT;
			tick_cnt   <= '0;
			score      <= '0;
		end
		else
		begin
			// Count clears, stick at max
			if (score_sum[starship_pkg::SCORE_W])
				score <= starship_pkg::SCORE_MAX;
			else
				score <= score_sum[starship_pkg::SCORE_W-1:0];

			case (game_state)
				starship_pkg::INIT:
					if (start_pulse)
					begin
						game_state <= starship_pkg::PLAY;
						tick_cnt   <= '0;               // Fresh tick phase
						score      <= '0;               // New game
					end
				starship_pkg::PLAY:
				begin
					tick_cnt <= tick_cnt + 1'b1;        // Wraps every TICK_CYCLES
					if (expired_top || expired_bottom)
						game_state <= starship_pkg::OVER;
				end
				starship_pkg::OVER:
					if (start_pulse)
						game_state <= starship_pkg::INIT;
				default:
					game_state <= starship_pkg::INIT;   // Unused code 3
			endcase
		end
	end

endmodule

/* source/monster_lane.sv */
// Monster lane: spawn wait, code latch, life timeout and switch-code clearing for one hatch
`timescale 1ns/1ps

module monster_lane
(
	input  logic                        board_clk,
	input  logic                        Reset,
	input  starship_pkg::game_state_t   game_state,
	input  logic                        game_tick,
	input  logic [3:0]                  rand_nibble,   // Code and wait source
	input  logic                        clear_pulse,   // Up or down button
	input  logic [3:0]                  sw,
	output logic                        full,          // Monster at the hatch
	output logic [3:0]                  code,          // Code to match
	output logic                        cleared,       // Correct answer
	output logic                        expired        // Monster waited too long
);

	// One counter: spawn wait while empty, remaining life while full
	logic [starship_pkg::LANE_W-1:0] cnt;
	logic [starship_pkg::LANE_W-1:0] cnt_dec;
	logic [starship_pkg::LANE_W-1:0] wait_load;
	logic                            playing;
	logic                            match;
	logic                            fill;

	assign playing = (game_state == starship_pkg::PLAY);
	assign cnt_dec = cnt - 1'b1;

	// SPAWN_BASE plus 0..7 random ticks
	assign wait_load = starship_pkg::LANE_SPAWN +
	                   (starship_pkg::LANE_W)'(rand_nibble[2:0]);

	// Right code on a full lane
	assign match = clear_pulse && full && (sw == code);

	// Wait ran out on this tick
	assign fill = playing && !match && game_tick && !full && (cnt_dec == '0);

	// ----------------------------------------
	// Lane control
	// ----------------------------------------
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
		begin
			full    <= 1'b0;
			cnt     <= '0;
			cleared <= 1'b0;
			expired <= 1'b0;
		end
		else
		begin
			cleared <= 1'b0;
			expired <= 1'b0;
			if (!playing)
			begin
				full <= 1'b0;                                // Empty outside PLAY
				cnt  <= wait_load;                           // Ready for the next start
			end
			else if (match)
			begin
				full    <= 1'b0;
				cnt     <= wait_load;                        // Next spawn wait
				cleared <= 1'b1;
			end
			else if (fill)
			begin
				full <= 1'b1;
				cnt  <= starship_pkg::LANE_LIFE;             // Start the life timer
			end
			else if (game_tick)
			begin
				cnt <= cnt_dec;
				if (full && (cnt_dec == '0))
					expired <= 1'b1;                         // Controller ends the game
			end
		end
	end

	// Code latched as the monster arrives
	always_ff @(posedge board_clk)
	begin
		if (fill)
			code <= rand_nibble;
	end

endmodule

/* source/ssd_scanner.sv */
// Seven-segment scanner: cycles eight digits and drives active-low anodes and cathodes
`timescale 1ns/1ps

module ssd_scanner
(
	input  logic                              board_clk,
	input  logic                              Reset,
	input  logic [3:0]                        sw,
	input  logic [3:0]                        code_top,
	input  logic                              full_top,
	input  logic [3:0]                        code_bottom,
	input  logic                              full_bottom,
	input  logic [starship_pkg::SCORE_W-1:0]  score,
	input  starship_pkg::game_state_t         game_state,
	output logic [7:0]                        an,      // Active low, one-hot
	output logic [7:0]                        seg      // a..g then dp, active low
);

	logic [starship_pkg::SCAN_W-1:0] scan_cnt;
	logic [2:0]                      slot;         // Lit digit
	logic [3:0]                      digit;        // Hex value of lit digit
	logic [6:0]                      cathodes;     // a..g

	// ----------------------------------------
	// Scan timing
	// ----------------------------------------
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
		begin
			scan_cnt <= '0;
			slot     <= 3'd0;
		end
		else if (scan_cnt == starship_pkg::SCAN_LAST)
		begin
			scan_cnt <= '0;
			slot     <= slot + 3'd1;           // 7 wraps to 0
		end
		else
			scan_cnt <= scan_cnt + 1'b1;
	end

	assign an = ~(8'b0000_0001 << slot);

	// Slot contents
	always_comb
	begin
		case (slot)
			3'd0:    digit = sw;
			3'd1:    digit = full_top ? code_top : 4'h0;           // Blank empty lane to 0
			3'd2:    digit = full_bottom ? code_bottom : 4'h0;
			3'd4:    digit = score[3:0];
			3'd5:    digit = score[7:4];
			3'd6:    digit = {2'b00, game_state};                   // State number
			default: digit = 4'h0;                                  // Slots 3 and 7
		endcase
	end

	// ----------------------------------------
	// Hex to cathodes
	// ----------------------------------------
	always_comb
	begin
		case (digit)
			4'h0:    cathodes = 7'b0000001;
			4'h1:    cathodes = 7'b1001111;
			4'h2:    cathodes = 7'b0010010;
			4'h3:    cathodes = 7'b0000110;
			4'h4:    cathodes = 7'b1001100;
			4'h5:    cathodes = 7'b0100100;
			4'h6:    cathodes = 7'b0100000;
			4'h7:    cathodes = 7'b0001111;
			4'h8:    cathodes = 7'b0000000;
			4'h9:    cathodes = 7'b0000100;
			4'hA:    cathodes = 7'b0001000;
			4'hB:    cathodes = 7'b1100000;     // Lower case b
			4'hC:    cathodes = 7'b0110001;
			4'hD:    cathodes = 7'b1000010;     // Lower case d
			4'hE:    cathodes = 7'b0110000;
			default: cathodes = 7'b0111000;     // F
		endcase
	end

	assign seg = {cathodes, 1'b1};              // Dot point kept dark

endmodule

/* source/starship_top.sv */
// Starship board top: debounced buttons, game controller, two monster lanes, LEDs and display
`timescale 1ns/1ps

module starship_top
(
	input  logic       board_clk,
	input  logic       Reset,
	input  logic       btn_c,      // Start / restart
	input  logic       btn_u,      // Answer top hatch
	input  logic       btn_d,      // Answer bottom hatch
	input  logic [3:0] sw,         // Player code
	output logic [7:0] led,
	output logic [7:0] an,
	output logic [7:0] seg
);

	logic start_pulse;
	logic top_pulse;
	logic bottom_pulse;

	starship_pkg::game_state_t          game_state;
	logic                               game_tick;
	logic [starship_pkg::SCORE_W-1:0]   score;
	logic [7:0]                         random_byte;

	logic       full_top, full_bottom;
	logic [3:0] code_top, code_bottom;
	logic       cleared_top, cleared_bottom;
	logic       expired_top, expired_bottom;

	// ----------------------------------------
	// Buttons
	// ----------------------------------------
	button_debouncer u_deb_c (.board_clk, .Reset, .btn(btn_c), .pulse(start_pulse));
	button_debouncer u_deb_u (.board_clk, .Reset, .btn(btn_u), .pulse(top_pulse));
	button_debouncer u_deb_d (.board_clk, .Reset, .btn(btn_d), .pulse(bottom_pulse));

	// ----------------------------------------
	// Game core
	// ----------------------------------------
	starship_game_fsm u_game (
		.board_clk, .Reset, .start_pulse,
		.cleared_top, .cleared_bottom, .expired_top, .expired_bottom,
		.game_state, .game_tick, .score
	);

	lfsr_random u_rand (.board_clk, .Reset, .step(game_tick), .random_byte);

	// Low nibble to the top hatch, high nibble to the bottom
	monster_lane u_lane_top (
		.board_clk, .Reset, .game_state, .game_tick,
		.rand_nibble(random_byte[3:0]), .clear_pulse(top_pulse), .sw,
		.full(full_top), .code(code_top), .cleared(cleared_top), .expired(expired_top)
	);

	monster_lane u_lane_bottom (
		.board_clk, .Reset, .game_state, .game_tick,
		.rand_nibble(random_byte[7:4]), .clear_pulse(bottom_pulse), .sw,
		.full(full_bottom), .code(code_bottom), .cleared(cleared_bottom),
		.expired(expired_bottom)
	);

	// ----------------------------------------
	// Outputs
	// ----------------------------------------
	ssd_scanner u_ssd (
		.board_clk, .Reset, .sw,
		.code_top, .full_top, .code_bottom, .full_bottom,
		.score, .game_state, .an, .seg
	);

	assign led[0]   = full_top;
	assign led[1]   = full_bottom;
	assign led[2]   = (game_state == starship_pkg::PLAY);
	assign led[3]   = (game_state == starship_pkg::OVER);
	assign led[7:4] = sw;                       // Echo the switches

endmodule

/* verif/starship_tb.sv */
// Starship testbench that replays the command file on the board top and checks LEDs and digits
`timescale 1ns/1ps

module starship_tb;

	localparam int SLOT_WAIT   = 16 * starship_pkg::SCAN_CYCLES;      // Two display scans
	localparam int LED_WAIT    = 4 * starship_pkg::DEBOUNCE_CYCLES;
	localparam int FILL_WAIT   = (starship_pkg::SPAWN_BASE + 10) * starship_pkg::TICK_CYCLES;
	localparam int EXPIRE_WAIT = (starship_pkg::SPAWN_BASE + starship_pkg::MONSTER_LIFE + 12)
	                             * starship_pkg::TICK_CYCLES;
	// Active-low a..g patterns from F down to 0
	localparam logic [16*7-1:0] HEX_SEG = {7'h38, 7'h30, 7'h42, 7'h31, 7'h60, 7'h08, 7'h04,
	                                       7'h00, 7'h0F, 7'h20, 7'h24, 7'h4C, 7'h06, 7'h12,
	                                       7'h4F, 7'h01};

	logic       board_clk;
	logic       Reset;
	logic       btn_c;
	logic       btn_u;
	logic       btn_d;
	logic [3:0] sw;
	logic [7:0] led;
	logic [7:0] an;
	logic [7:0] seg;
	int         seed = 32'hcc9;
	int         test_errors = 0;
	int         failed_tests = 0;
	int         run_tests = 0;
	int         score_model = 0;    // Clears counted since the last start
	string      name;
	string      cmd;
	logic [7:0] expv;

	starship_top UUT (.board_clk, .Reset, .btn_c, .btn_u, .btn_d, .sw, .led, .an, .seg);

	initial board_clk = 1'b0;
	always #2 board_clk = ~board_clk;

	// Anode select checked mid-cycle
	always @(negedge board_clk)
		if (Reset === 1'b0)
			assert ((~an != 8'h00) && ((~an & (~an - 8'h01)) == 8'h00))
			else
			begin
				$display("%s: anode select is not one-hot, an=%b", name, an);
				test_errors++;
			end

	function automatic int press_length();
		press_length = starship_pkg::DEBOUNCE_CYCLES + 2 + ({$random(seed)} % 8);
	endfunction

	task automatic check_value(input logic [7:0] expected, input logic [7:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
			test_errors++;
		end
	endtask

	// Centre is 0, up 1 and down 2. Returns after the re-arm window
	task automatic press_button(input int which, input int cycles);
		@(posedge board_clk);
		#1 {btn_d, btn_u, btn_c} = 3'b001 << which;
		repeat (cycles) @(posedge board_clk);
		#1 {btn_d, btn_u, btn_c} = 3'b000;
		repeat (starship_pkg::DEBOUNCE_CYCLES + 4) @(posedge board_clk);
	endtask

	task automatic drive_sw(input logic [3:0] value);
		@(posedge board_clk);
		#1 sw = value;
	endtask

	task automatic wait_leds(input logic [3:0] mask, input logic [3:0] value, input int limit);
		int n;
		n = 0;
		@(negedge board_clk);
		while (((led[3:0] & mask) !== value) && (n < limit))
		begin
			@(negedge board_clk);
			n++;
		end
		assert ((led[3:0] & mask) === value)
		else
		begin
			$display("%s: led[3:0] never reached %b under mask %b in %0d cycles, still %b",
			         name, value, mask, limit, led[3:0]);
			test_errors++;
		end
	endtask

	// Wait for the slot to light and map cathodes back to hex
	task automatic read_slot(input int s, output logic [3:0] value);
		int n;
		int i;
		logic found;
		n = 0;
		found = 1'b0;
		value = 4'h0;
		@(negedge board_clk);
		while ((an !== ~(8'b1 << s)) && (n < SLOT_WAIT))
		begin
			@(negedge board_clk);
			n++;
		end
		assert (an === ~(8'b1 << s))
		else
		begin
			$display("%s: digit slot %0d never lit within %0d cycles", name, s, SLOT_WAIT);
			test_errors++;
		end
		for (i = 0; i < 16; i++)
			if (seg[7:1] === HEX_SEG[i*7 +: 7])
			begin
				value = i[3:0];
				found = 1'b1;
			end
		assert (found && (seg[0] === 1'b1))         // dp dark too
		else
		begin
			$display("%s: slot %0d shows no hex digit, seg=%b", name, s, seg);
			test_errors++;
		end
	endtask

	task automatic read_score(output logic [7:0] score);
		read_slot(4, score[3:0]);
		read_slot(5, score[7:4]);
	endtask

	// ----------------------------------------
	// Lane clear for top (0) or bottom (1)
	// ----------------------------------------
	task automatic clear_lane(input int lane);
		logic [3:0] code;
		logic [7:0] score;
		wait_leds(4'b0001 << lane, 4'b0001 << lane, FILL_WAIT);   // Monster arrives
		read_slot(1 + lane, code);
		drive_sw(code);
		press_button(1 + lane, press_length());
		wait_leds(4'b0001 << lane, 4'b0000, LED_WAIT);           // Hatch empties
		score_model++;
		read_score(score);
		check_value(score_model, score);
	endtask

	task automatic run_command();
		logic [3:0] val;
		logic [7:0] score;
		int i;
		if (cmd == "leds")
		begin
			@(negedge board_clk);
			check_value(expv, led[3:0]);
		end
		else if (cmd == "slot0" || cmd == "slot6")
		begin
			if (cmd == "slot0")
				drive_sw(expv[3:0]);
			read_slot((cmd == "slot0") ? 0 : 6, val);
			check_value(expv, val);
			if (cmd == "slot0")
				check_value(expv[3:0], led[7:4]);                // Switch echo LEDs
		end
		else if (cmd == "short_c")
		begin
			press_button(0, starship_pkg::DEBOUNCE_CYCLES - 2);   // Too short to count
			@(negedge board_clk);
			check_value(expv, led[2]);
		end
		else if (cmd == "press_c")
		begin
			press_button(0, press_length());
			wait_leds(4'hF, expv[3:0], LED_WAIT);
			if (expv[2])
				score_model = 0;                                  // New game
		end
		else if (cmd == "wrong_u")
		begin
			wait_leds(4'b0001, 4'b0001, FILL_WAIT);
			read_slot(1, val);
			drive_sw(~val);                                       // Never the shown code
			press_button(1, press_length());
			@(negedge board_clk);
			check_value(1, led[0]);
			read_score(score);
			check_value(expv, score);
		end
		else if (cmd == "rounds")
			for (i = 0; i < expv; i++)
			begin
				clear_lane(0);
				clear_lane(1);
			end
		else if (cmd == "score")
		begin
			read_score(score);
			check_value(expv, score);
		end
		else if (cmd == "expire")
		begin
			wait_leds(4'b1100, 4'b1000, EXPIRE_WAIT);             // OVER and not PLAY
			read_slot(6, val);
			check_value(expv, val);
		end
		else
		begin
			$display("%s: unknown command %s", name, cmd);
			test_errors++;
		end
	endtask

	// ----------------------------------------
	// Command loop
	// ----------------------------------------
	initial
	begin
		int fd;
		int rc;
		string line;
		Reset = 1'b1;
		btn_c = 1'b0;
		btn_u = 1'b0;
		btn_d = 1'b0;
		sw    = 4'h0;
		repeat (8) @(posedge board_clk);
		#1 Reset = 1'b0;
		fd = $fopen("verif/starship_stimulus.txt", "r");
		if (fd == 0)
			$display("Could not open the stimulus file");
		else
		begin
			while (!$feof(fd))
			begin
				rc = $fgets(line, fd);
				if (rc == 0 || line.len() < 2 || line.getc(0) == "#")
					continue;                                 // Blank or comment
				rc = $sscanf(line, "%s %s %h", name, cmd, expv);
				if (rc != 3)
					continue;
				test_errors = 0;
				run_command();
				run_tests++;
				if (test_errors == 0)
					$display("PASS %s", name);
				else
				begin
					$display("FAIL %s with %0d errors", name, test_errors);
					failed_tests++;
				end
			end
			$fclose(fd);
		end
		$display("Tests run %0d, failed %0d", run_tests, failed_tests);
		if (failed_tests == 0 && run_tests > 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Whole-run limit
	initial
	begin
		#400000;
		$display("Run time limit reached before the command file finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* verif/starship_stimulus.txt */
# name command expected, expected in hex
# leds slot0 slot6 short_c press_c wrong_u rounds score expire
reset_leds   leds    0
reset_state  slot6   0
switch_echo  slot0   a
short_press  short_c 0
start_game   press_c 4
play_state   slot6   1
wrong_code   wrong_u 0
clear_rounds rounds  3
lose_game    expire  2
back_to_init press_c 0
restart_game press_c 4
fresh_score  score   0

/* sim.f */
source/starship_pkg.sv
source/button_debouncer.sv
source/lfsr_random.sv
source/starship_game_fsm.sv
source/monster_lane.sv
source/ssd_scanner.sv
source/starship_top.sv
verif/starship_tb.sv
